/* alu_settings.svh */
//////////////////////////////////////////////////
// ALU build settings
// data word, byte lane split and divider length
//////////////////////////////////////////////////

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// full data word
`define ALU_WIDTH 32

// byte lanes inside one word
`define ALU_LANES 4
`define ALU_LANE_W 8

// restoring steps per division, one quotient bit each
`define DIV_ITER 32

`endif

/* alu_pkg.sv */
//////////////////////////////////////////////////
// ALU shared types
// words, lane masks, operator encoding and request
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

package alu_pkg;

  typedef logic [`ALU_WIDTH-1:0] word_t;
  // one flag per byte lane
  typedef logic [`ALU_LANES-1:0] lane_mask_t;

  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // divide group: bit 0 is signed, bit 1 is remainder
  typedef enum logic [5:0] {
    ALU_AND  = 6'h00, ALU_OR   = 6'h01, ALU_XOR  = 6'h02,
    ALU_ADD  = 6'h04, ALU_SUB  = 6'h05,
    ALU_SLL  = 6'h08, ALU_SRL  = 6'h09, ALU_SRA  = 6'h0a, ALU_ROR  = 6'h0b,
    ALU_EQ   = 6'h10, ALU_NE   = 6'h11,
    ALU_GTS  = 6'h12, ALU_GES  = 6'h13, ALU_LTS  = 6'h14, ALU_LES  = 6'h15,
    ALU_GTU  = 6'h16, ALU_GEU  = 6'h17, ALU_LTU  = 6'h18, ALU_LEU  = 6'h19,
    ALU_SLTS = 6'h1a, ALU_SLTU = 6'h1b,
    ALU_MIN  = 6'h20, ALU_MINU = 6'h21, ALU_MAX  = 6'h22, ALU_MAXU = 6'h23,
    ALU_ABS  = 6'h24,
    ALU_DIVU = 6'h30, ALU_DIV  = 6'h31, ALU_REMU = 6'h32, ALU_REM  = 6'h33
  } alu_op_e;

  // one request as seen by every unit
  typedef struct packed {
    alu_op_e   op;
    vec_mode_e vec_mode;
    word_t     operand_a;
    word_t     operand_b;
  } alu_req_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

endpackage

`default_nettype wire

/* alu_vec_adder.sv */
//////////////////////////////////////////////////
// lane-partitioned adder
// add, sub and per-lane negation of operand A
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module alu_vec_adder
  import alu_pkg::*;
(
  input  alu_req_t req_i,
  output word_t    sum_o
);

  localparam int LW      = `ALU_LANE_W;
  // one spacer bit below every lane
  localparam int SLICE_W = LW + 1;
  localparam int EXP_W   = `ALU_LANES * SLICE_W;

  logic             is_abs;
  logic             is_sub;
  logic             negate;
  lane_mask_t       cut;
  word_t            op_a;
  word_t            op_b;
  logic [EXP_W-1:0] in_a;
  logic [EXP_W-1:0] in_b;
  logic [EXP_W-1:0] sum_exp;

  assign is_abs = (req_i.op == ALU_ABS);
  assign is_sub = (req_i.op == ALU_SUB);
  assign negate = is_sub | is_abs;

  // abs builds 0 - a as ~a + 1
  assign op_a = is_abs ? ~req_i.operand_a : req_i.operand_a;
  assign op_b = is_abs ? '0 : (is_sub ? ~req_i.operand_b : req_i.operand_b);

  // lane borders where the carry chain is broken
  // bit 0 is the carry-in position of the low lane
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE16: cut = 4'b0101;
      VEC_MODE8:  cut = 4'b1111;
      default:    cut = 4'b0001;
    endcase
  end

  for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
    // spacer 1+1 injects a carry, 1+0 passes it, 0+0 kills it
    assign in_a[SLICE_W*i] = negate | ~cut[i];
    assign in_b[SLICE_W*i] = negate & cut[i];
    assign in_a[SLICE_W*i+1 +: LW] = op_a[LW*i +: LW];
    assign in_b[SLICE_W*i+1 +: LW] = op_b[LW*i +: LW];
    // drop the spacer bits again
    assign sum_o[LW*i +: LW] = sum_exp[SLICE_W*i+1 +: LW];
  end

  assign sum_exp = in_a + in_b;

endmodule

`default_nettype wire

/* alu_vec_shifter.sv */
//////////////////////////////////////////////////
// per-lane shifter
// right shifts per lane, left via bit reversal
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module alu_vec_shifter
  import alu_pkg::*;
(
  input  alu_req_t req_i,
  output word_t    shift_o
);

  localparam int W = `ALU_WIDTH;

  logic           shift_left;
  logic           arith;
  logic           rotate;
  vec_mode_e      mode;
  word_t          op_a;
  word_t          op_a_rev;
  word_t          amt_rev;
  word_t          amt;
  word_t          res16;
  word_t          res8;
  word_t          right_res;
  word_t          right_rev;
  logic [2*W-1:0] wide_a;
  logic [2*W-1:0] wide_res;

  assign shift_left = (req_i.op == ALU_SLL);
  assign arith      = (req_i.op == ALU_SRA);
  assign rotate     = (req_i.op == ALU_ROR);
  // rotate always works on the full word
  assign mode       = rotate ? VEC_MODE32 : req_i.vec_mode;

  for (genvar k = 0; k < W; k++) begin : g_rev
    assign op_a_rev[k]  = req_i.operand_a[W-1-k];
    assign right_rev[k] = right_res[W-1-k];
  end

  assign op_a = shift_left ? op_a_rev : req_i.operand_a;

  // reversed data also flips the lane order of the amounts
  always_comb begin
    case (mode)
      VEC_MODE16: amt_rev = {req_i.operand_b[15:0], req_i.operand_b[31:16]};
      VEC_MODE8:  amt_rev = {req_i.operand_b[7:0], req_i.operand_b[15:8],
                             req_i.operand_b[23:16], req_i.operand_b[31:24]};
      default:    amt_rev = req_i.operand_b;
    endcase
  end

  assign amt = shift_left ? amt_rev : req_i.operand_b;

  ////////////////////////////////////////////////////
  // lane shifters
  ////////////////////////////////////////////////////

  // 32-bit mode, upper half holds sign fill or the rotate copy
  assign wide_a   = rotate ? {op_a, op_a} : {{W{arith & op_a[W-1]}}, op_a};
  assign wide_res = wide_a >> amt[4:0];

  for (genvar h = 0; h < 2; h++) begin : g_half
    logic [16:0] ext;
    assign ext = $signed({arith & op_a[16*h+15], op_a[16*h +: 16]}) >>> amt[16*h +: 4];
    assign res16[16*h +: 16] = ext[15:0];
  end

  for (genvar b = 0; b < 4; b++) begin : g_byte
    logic [8:0] ext;
    assign ext = $signed({arith & op_a[8*b+7], op_a[8*b +: 8]}) >>> amt[8*b +: 3];
    assign res8[8*b +: 8] = ext[7:0];
  end

  always_comb begin
    case (mode)
      VEC_MODE16: right_res = res16;
      VEC_MODE8:  right_res = res8;
      default:    right_res = wide_res[W-1:0];
    endcase
  end

  // undo the input reversal for left shifts
  assign shift_o = shift_left ? right_rev : right_res;

endmodule

`default_nettype wire

/* alu_vec_compare.sv */
//////////////////////////////////////////////////
// vector comparison unit
// lane compares, set-less-than, min/max/abs pick
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module alu_vec_compare
  import alu_pkg::*;
(
  input  alu_req_t req_i,
  input  word_t    neg_a_i,
  output word_t    cmp_word_o,
  output word_t    minmax_o,
  output logic     comparison_result_o
);

  localparam int LW = `ALU_LANE_W;

  logic       is_signed_op;
  logic       is_scalar;
  logic       is_abs;
  logic       do_min;
  vec_mode_e  mode;
  lane_mask_t cmp_signed;
  lane_mask_t eq_vec;
  lane_mask_t gt_vec;
  lane_mask_t is_equal;
  lane_mask_t is_greater;
  lane_mask_t cmp_res;
  lane_mask_t sel;
  word_t      cmp_b;
  word_t      minmax_b;
  word_t      lane_word;

  assign is_signed_op = req_i.op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS,
                                         ALU_MIN, ALU_MAX, ALU_ABS};
  assign is_scalar    = req_i.op inside {ALU_SLTS, ALU_SLTU};
  assign is_abs       = (req_i.op == ALU_ABS);
  assign do_min       = req_i.op inside {ALU_MIN, ALU_MINU};
  // scalar set-less-than always looks at the whole word
  assign mode         = is_scalar ? VEC_MODE32 : req_i.vec_mode;

  // sign bit only lives in the top byte of each lane
  always_comb begin
    case (mode)
      VEC_MODE8:  cmp_signed = {`ALU_LANES{is_signed_op}};
      VEC_MODE16: cmp_signed = {is_signed_op, 1'b0, is_signed_op, 1'b0};
      default:    cmp_signed = {is_signed_op, 3'b000};
    endcase
  end

  // abs compares against zero, picks a or -a
  assign cmp_b    = is_abs ? '0 : req_i.operand_b;
  assign minmax_b = is_abs ? neg_a_i : req_i.operand_b;

  for (genvar i = 0; i < `ALU_LANES; i++) begin : g_byte
    logic [LW-1:0] a_byte;
    logic [LW-1:0] b_byte;
    assign a_byte    = req_i.operand_a[LW*i +: LW];
    assign b_byte    = cmp_b[LW*i +: LW];
    assign eq_vec[i] = (a_byte == b_byte);
    // extra top bit turns the unsigned byte compare into a signed one
    assign gt_vec[i] = $signed({cmp_signed[i] & a_byte[LW-1], a_byte})
                     > $signed({cmp_signed[i] & b_byte[LW-1], b_byte});
    assign minmax_o[LW*i +: LW]  = sel[i] ? a_byte : minmax_b[LW*i +: LW];
    assign lane_word[LW*i +: LW] = {LW{cmp_res[i]}};
  end

  ////////////////////////////////////////////////////
  // merge bytes into lanes
  ////////////////////////////////////////////////////

  always_comb begin
    case (mode)
      VEC_MODE8: begin
        is_equal   = eq_vec;
        is_greater = gt_vec;
      end
      VEC_MODE16: begin
        is_equal[1:0]   = {2{eq_vec[1] & eq_vec[0]}};
        is_equal[3:2]   = {2{eq_vec[3] & eq_vec[2]}};
        is_greater[1:0] = {2{gt_vec[1] | (eq_vec[1] & gt_vec[0])}};
        is_greater[3:2] = {2{gt_vec[3] | (eq_vec[3] & gt_vec[2])}};
      end
      default: begin
        is_equal   = {`ALU_LANES{&eq_vec}};
        // high byte decides unless equal, then the next one down
        is_greater = {`ALU_LANES{gt_vec[3] | (eq_vec[3] & (gt_vec[2] | (eq_vec[2] &
                     (gt_vec[1] | (eq_vec[1] & gt_vec[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      ALU_NE:                               cmp_res = ~is_equal;
      ALU_GTS, ALU_GTU:                     cmp_res = is_greater;
      ALU_GES, ALU_GEU:                     cmp_res = is_greater | is_equal;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_res = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU:                     cmp_res = ~is_greater;
      default:                              cmp_res = is_equal;
    endcase
  end

  assign comparison_result_o = cmp_res[`ALU_LANES-1];
  assign cmp_word_o = is_scalar ? {{(`ALU_WIDTH-1){1'b0}}, comparison_result_o} : lane_word;

  // keep a where it wins, flipped for min
  assign sel = is_greater ^ {`ALU_LANES{do_min}};

endmodule

`default_nettype wire

/* alu_serial_div.sv */
//////////////////////////////////////////////////
// iterative divider
// fixed-length restoring divide and remainder
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module alu_serial_div
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     enable_i,
  input  alu_req_t req_i,
  input  logic     ex_ready_i,
  output word_t    div_o,
  output logic     ready_o
);

  localparam int W     = `ALU_WIDTH;
  localparam int CNT_W = $clog2(`DIV_ITER + 1);

  div_state_e       state;
  logic [CNT_W-1:0] cnt;
  word_t            quo;
  word_t            rem;
  word_t            divisor;
  logic             neg_q;
  logic             neg_r;
  logic             is_rem;
  logic             is_div;
  logic             op_signed;
  logic             start;
  logic             a_neg;
  logic             b_neg;
  word_t            a_mag;
  word_t            b_mag;
  // one bit wider so the sign shows whether the step fits
  logic [W:0]       trial;

  assign is_div    = req_i.op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  assign op_signed = req_i.op[0];
  assign a_neg     = op_signed & req_i.operand_a[W-1];
  assign b_neg     = op_signed & req_i.operand_b[W-1];
  assign a_mag     = a_neg ? -req_i.operand_a : req_i.operand_a;
  assign b_mag     = b_neg ? -req_i.operand_b : req_i.operand_b;
  assign start     = (state == DIV_IDLE) & enable_i & is_div;

  // shift in the next dividend bit and try the subtract
  assign trial = {rem, quo[W-1]} - {1'b0, divisor};

  ////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= DIV_IDLE;
      cnt   <= '0;
      quo   <= '0;
      rem   <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (start) begin
            state <= DIV_BUSY;
            cnt   <= '0;
            quo   <= a_mag;
            rem   <= '0;
          end
        end
        DIV_BUSY: begin
          if (cnt == CNT_W'(`DIV_ITER)) begin
            // extra cycle after the last step applies the signs
            quo   <= neg_q ? -quo : quo;
            rem   <= neg_r ? -rem : rem;
            state <= DIV_DONE;
          end else begin
            cnt <= cnt + 1'b1;
            if (!trial[W]) begin
              rem <= trial[W-1:0];
              quo <= {quo[W-2:0], 1'b1};
            end else begin
              rem <= {rem[W-2:0], quo[W-1]};
              quo <= {quo[W-2:0], 1'b0};
            end
          end
        end
        DIV_DONE: begin
          // hold the result until the pipeline takes it
          if (ex_ready_i) state <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // operand side info captured at start
  always_ff @(posedge clk) begin
    if (start) begin
      divisor <= b_mag;
      // division by zero keeps the all-ones quotient
      neg_q   <= (a_neg ^ b_neg) & (req_i.operand_b != '0);
      neg_r   <= a_neg;
      is_rem  <= req_i.op[1];
    end
  end

  assign div_o   = is_rem ? rem : quo;
  assign ready_o = (state == DIV_DONE) | ((state == DIV_IDLE) & ~(enable_i & is_div));

endmodule

`default_nettype wire

/* alu_top.sv */
//////////////////////////////////////////////////
// execute stage ALU
// unit instances and the result mux
//////////////////////////////////////////////////

`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  logic      enable_i,
  input  alu_op_e   operator_i,
  input  vec_mode_e vector_mode_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      comparison_result_o,
  output logic      ready_o
);

  alu_req_t req;
  word_t    sum;
  word_t    shift_res;
  word_t    cmp_word;
  word_t    minmax_res;
  word_t    div_res;

  // one request bundle for all units
  assign req = '{op:        operator_i,
                 vec_mode:  vector_mode_i,
                 operand_a: operand_a_i,
                 operand_b: operand_b_i};

  ////////////////////////////////////////////////////
  // units
  ////////////////////////////////////////////////////

  alu_vec_adder u_adder (
    .req_i (req),
    .sum_o (sum)
  );

  alu_vec_shifter u_shifter (
    .req_i   (req),
    .shift_o (shift_res)
  );

  // abs takes the negated lanes from the adder
  alu_vec_compare u_compare (
    .req_i               (req),
    .neg_a_i             (sum),
    .cmp_word_o          (cmp_word),
    .minmax_o            (minmax_res),
    .comparison_result_o (comparison_result_o)
  );

  alu_serial_div u_div (
    .clk        (clk),
    .rst_i      (rst_i),
    .enable_i   (enable_i),
    .req_i      (req),
    .ex_ready_i (ex_ready_i),
    .div_o      (div_res),
    .ready_o    (ready_o)
  );

  ////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_ADD, ALU_SUB: result_o = sum;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR: result_o = shift_res;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
      ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU, ALU_SLTS, ALU_SLTU: result_o = cmp_word;
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS: result_o = minmax_res;
      // only meaningful once the divider reports ready
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: result_o = div_res;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* tb_alu_sva.sv */
//////////////////////////////////////////////////
// handshake assertions for the ALU
// bound into alu_top
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module tb_alu_sva
  import alu_pkg::*;
(
  input wire        clk_i,
  input wire        rst_i,
  input wire        enable_i,
  input wire        ex_ready_i,
  input wire        ready_o,
  input word_t      result_o,
  input div_state_e div_state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // ready stays low through every busy step and returns with the result
  a_busy_not_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (div_state_i == DIV_IDLE && enable_i && !ready_o)
      |=> !ready_o [*(`DIV_ITER + 1)] ##1 ready_o)
    else $error("ready_o not low for the whole divide");

  // stalled pipeline sees a frozen result
  a_hold_result: assert property (@(posedge clk_i) disable iff (rst_i)
    (enable_i && ready_o && !ex_ready_i) |=> $stable(result_o))
    else $error("result_o changed under back-pressure");

  // stalled pipeline keeps seeing ready
  a_hold_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (enable_i && ready_o && !ex_ready_i) |=> ready_o)
    else $error("ready_o dropped under back-pressure");

endmodule

bind alu_top tb_alu_sva u_sva (
  .clk_i       (clk),
  .rst_i       (rst_i),
  .enable_i    (enable_i),
  .ex_ready_i  (ex_ready_i),
  .ready_o     (ready_o),
  .result_o    (result_o),
  .div_state_i (u_div.state)
);

`default_nettype wire

/* tb_alu_checker.sv */
//////////////////////////////////////////////////
// ALU checker
// reference model, per-test compare and report
//////////////////////////////////////////////////

`include "alu_settings.svh"
`default_nettype none

module tb_alu_checker
  import alu_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_i,
  input  wire          enable_i,
  input  wire          ex_ready_i,
  input  alu_op_e      operator_i,
  input  vec_mode_e    vector_mode_i,
  input  word_t        operand_a_i,
  input  word_t        operand_b_i,
  input  word_t        exp_i,
  input  wire          use_model_i,
  input  wire [127:0]  name_i,
  input  wire          dut_ready_i,
  input  word_t        dut_result_i,
  input  wire          dut_cmp_i,
  output int           n_checked_o,
  output int           n_errors_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // lane-by-lane model written from the operator rules
  function automatic word_t model(input alu_op_e op, input vec_mode_e mode,
                                  input word_t a, input word_t b);
    int     lw;
    int     sh;
    longint mask;
    longint av;
    longint bv;
    longint sa;
    longint sb;
    longint r;
    word_t  res;
    case (op)
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_ROR:  return (a >> b[4:0]) | (a << (6'd32 - {1'b0, b[4:0]}));
      ALU_SLTS: return {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_DIVU: return (b == '0) ? '1 : a / b;
      ALU_REMU: return (b == '0) ? a : a % b;
      ALU_DIV: begin
        if (b == '0) return '1;
        if (a == 32'h8000_0000 && b == '1) return a;
        return word_t'($signed(a) / $signed(b));
      end
      ALU_REM: begin
        if (b == '0) return a;
        if (a == 32'h8000_0000 && b == '1) return '0;
        return word_t'($signed(a) % $signed(b));
      end
      default: ;
    endcase
    lw   = (mode == VEC_MODE8) ? 8 : ((mode == VEC_MODE16) ? 16 : 32);
    mask = (longint'(1) << lw) - 1;
    res  = '0;
    for (int l = 0; l < 32 / lw; l++) begin
      av = (longint'(a) >> (l * lw)) & mask;
      bv = (longint'(b) >> (l * lw)) & mask;
      // sign-extend the lane values
      sa = ((av >> (lw - 1)) & 1) != 0 ? av - (mask + 1) : av;
      sb = ((bv >> (lw - 1)) & 1) != 0 ? bv - (mask + 1) : bv;
      sh = int'(bv & (lw - 1));
      case (op)
        ALU_ADD:  r = av + bv;
        ALU_SUB:  r = av - bv;
        ALU_SLL:  r = av << sh;
        ALU_SRL:  r = av >> sh;
        ALU_SRA:  r = sa >>> sh;
        ALU_EQ:   r = (av == bv) ? mask : 0;
        ALU_NE:   r = (av != bv) ? mask : 0;
        ALU_GTS:  r = (sa > sb) ? mask : 0;
        ALU_GES:  r = (sa >= sb) ? mask : 0;
        ALU_LTS:  r = (sa < sb) ? mask : 0;
        ALU_LES:  r = (sa <= sb) ? mask : 0;
        ALU_GTU:  r = (av > bv) ? mask : 0;
        ALU_GEU:  r = (av >= bv) ? mask : 0;
        ALU_LTU:  r = (av < bv) ? mask : 0;
        ALU_LEU:  r = (av <= bv) ? mask : 0;
        ALU_MIN:  r = (sa < sb) ? av : bv;
        ALU_MINU: r = (av < bv) ? av : bv;
        ALU_MAX:  r = (sa > sb) ? av : bv;
        ALU_MAXU: r = (av > bv) ? av : bv;
        // most negative lane wraps back onto itself
        ALU_ABS:  r = (sa < 0) ? -sa : sa;
        default:  r = 0;
      endcase
      res = res | word_t'((r & mask) << (l * lw));
    end
    return res;
  endfunction

  word_t exp_val;
  logic  exp_cmp;
  logic  is_cmp;
  logic  counting;
  int    div_edges;
  int    test_errs;

  initial begin
    n_checked_o = 0;
    n_errors_o  = 0;
    counting    = 1'b0;
    div_edges   = 0;
    test_errs   = 0;
  end

  ////////////////////////////////////////////////////
  // divider latency, start edge to first ready
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (counting && dut_ready_i) begin
        counting = 1'b0;
        if (div_edges != `DIV_ITER + 1) begin
          $display("divider ready after %0d edges instead of %0d in test %0d %0s",
                   div_edges, `DIV_ITER + 1, n_checked_o, name_i);
          test_errs++;
        end
      end else if (counting) begin
        div_edges++;
      end else if (enable_i && !dut_ready_i &&
                   operator_i inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU}) begin
        counting  = 1'b1;
        div_edges = 0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // compare at each completing edge
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i && enable_i && dut_ready_i && ex_ready_i) begin
      exp_val = use_model_i ? model(operator_i, vector_mode_i, operand_a_i, operand_b_i)
                            : exp_i;
      is_cmp  = operator_i inside {ALU_EQ, ALU_NE, ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
                                   ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU, ALU_SLTS, ALU_SLTU};
      // scalar result sits in bit 0, vector top lane in bit 31
      exp_cmp = (operator_i inside {ALU_SLTS, ALU_SLTU}) ? exp_val[0] : exp_val[31];
      if (dut_result_i !== exp_val) begin
        $display("Mismatch test %0d %0s expected %h actual %h",
                 n_checked_o, name_i, exp_val, dut_result_i);
        test_errs++;
      end
      if (is_cmp && dut_cmp_i !== exp_cmp) begin
        $display("Mismatch test %0d %0s comparison_result expected %b actual %b",
                 n_checked_o, name_i, exp_cmp, dut_cmp_i);
        test_errs++;
      end
      if (test_errs == 0) begin
        $display("test %0d %0s ok, result %h", n_checked_o, name_i, dut_result_i);
      end else begin
        n_errors_o = n_errors_o + 1;
      end
      test_errs   = 0;
      n_checked_o = n_checked_o + 1;
    end
  end

endmodule

`default_nettype wire

/* tb_alu.sv */
//////////////////////////////////////////////////
// ALU testbench top
// clock, reset, stimulus table and watchdog
//////////////////////////////////////////////////

`default_nettype none

module tb_alu
  import alu_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [127:0] name;
    alu_op_e      op;
    vec_mode_e    mode;
    word_t        a;
    word_t        b;
    word_t        exp;
    logic         use_model;
  } test_t;

  logic         clk;
  logic         rst_i;
  logic         enable_i;
  alu_op_e      operator_i;
  vec_mode_e    vector_mode_i;
  word_t        operand_a_i;
  word_t        operand_b_i;
  logic         ex_ready_i;
  word_t        result_o;
  logic         comparison_result_o;
  logic         ready_o;
  word_t        exp_val;
  logic         use_model;
  logic [127:0] test_name;
  int           n_checked;
  int           n_errors;
  test_t        tests[$];
  alu_op_e      ops[$];
  integer       seed;
  int           limit_ns;

  always #2 clk = ~clk;

  alu_top UUT (
    .clk                 (clk),
    .rst_i               (rst_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .ex_ready_i          (ex_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .ready_o             (ready_o)
  );

  tb_alu_checker u_checker (
    .clk_i         (clk),
    .rst_i         (rst_i),
    .enable_i      (enable_i),
    .ex_ready_i    (ex_ready_i),
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .exp_i         (exp_val),
    .use_model_i   (use_model),
    .name_i        (test_name),
    .dut_ready_i   (ready_o),
    .dut_result_i  (result_o),
    .dut_cmp_i     (comparison_result_o),
    .n_checked_o   (n_checked),
    .n_errors_o    (n_errors)
  );

  task automatic add_test(input logic [127:0] nm, input alu_op_e op, input vec_mode_e m,
                          input word_t a, input word_t b, input word_t e);
    tests.push_back('{name: nm, op: op, mode: m, a: a, b: b, exp: e, use_model: 1'b0});
  endtask

  ////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////

  task automatic build_table();
    alu_op_e   op;
    vec_mode_e m;
    int        r;
    add_test("and_basic", ALU_AND, VEC_MODE32, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h00f0_f000);
    add_test("or_basic", ALU_OR, VEC_MODE32, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hfff0_fff0);
    add_test("xor_basic", ALU_XOR, VEC_MODE32, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'hff00_0ff0);
    add_test("add32_wrap", ALU_ADD, VEC_MODE32, 32'hffff_ffff, 32'h0000_0001, 32'h0);
    add_test("add16_lanes", ALU_ADD, VEC_MODE16, 32'hffff_7fff, 32'h0001_0001, 32'h0000_8000);
    add_test("add8_lanes", ALU_ADD, VEC_MODE8, 32'hff80_7f01, 32'h0180_0101, 32'h0000_8002);
    add_test("sub8_lanes", ALU_SUB, VEC_MODE8, 32'h0, 32'h0102_0304, 32'hfffe_fdfc);
    add_test("sub16_lanes", ALU_SUB, VEC_MODE16, 32'h0000_0005, 32'h0001_0006, 32'hffff_ffff);
    add_test("sll32", ALU_SLL, VEC_MODE32, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
    add_test("sll8", ALU_SLL, VEC_MODE8, 32'h8181_8181, 32'h0102_0309, 32'h0204_0802);
    add_test("sra16", ALU_SRA, VEC_MODE16, 32'h8000_7ff0, 32'h0004_0011, 32'hf800_3ff8);
    add_test("srl8", ALU_SRL, VEC_MODE8, 32'h80ff_4010, 32'h0701_0204, 32'h017f_1001);
    add_test("ror_word", ALU_ROR, VEC_MODE8, 32'h1234_5678, 32'h0000_0008, 32'h7812_3456);
    add_test("eq8", ALU_EQ, VEC_MODE8, 32'h1122_3344, 32'h1100_3300, 32'hff00_ff00);
    add_test("gts8", ALU_GTS, VEC_MODE8, 32'h807f_01ff, 32'h7f80_0000, 32'h00ff_ff00);
    add_test("gtu8", ALU_GTU, VEC_MODE8, 32'h807f_01ff, 32'h7f80_0000, 32'hff00_ffff);
    add_test("lts16", ALU_LTS, VEC_MODE16, 32'h8000_0001, 32'h0001_0001, 32'hffff_0000);
    add_test("leu32", ALU_LEU, VEC_MODE32, 32'h0000_0005, 32'h0000_0005, 32'hffff_ffff);
    add_test("slts", ALU_SLTS, VEC_MODE8, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
    add_test("sltu", ALU_SLTU, VEC_MODE8, 32'hffff_ffff, 32'h0000_0001, 32'h0);
    add_test("min8", ALU_MIN, VEC_MODE8, 32'h8005_7f10, 32'h7f06_8010, 32'h8005_8010);
    add_test("maxu16", ALU_MAXU, VEC_MODE16, 32'h8000_0001, 32'h7fff_0002, 32'h8000_0002);
    add_test("abs8", ALU_ABS, VEC_MODE8, 32'h80ff_05fb, 32'h0, 32'h8001_0505);
    add_test("abs32", ALU_ABS, VEC_MODE32, 32'hffff_fff6, 32'h0, 32'h0000_000a);
    add_test("div_neg", ALU_DIV, VEC_MODE32, 32'hffff_fff9, 32'h2, 32'hffff_fffd);
    add_test("rem_neg", ALU_REM, VEC_MODE32, 32'hffff_fff9, 32'h2, 32'hffff_ffff);
    add_test("divu", ALU_DIVU, VEC_MODE32, 32'h0000_0064, 32'h7, 32'h0000_000e);
    add_test("remu", ALU_REMU, VEC_MODE32, 32'h0000_0064, 32'h7, 32'h0000_0002);
    add_test("div_by_zero", ALU_DIV, VEC_MODE32, 32'h0000_1234, 32'h0, 32'hffff_ffff);
    add_test("rem_by_zero", ALU_REM, VEC_MODE32, 32'h0000_1234, 32'h0, 32'h0000_1234);
    add_test("divu_by_zero", ALU_DIVU, VEC_MODE32, 32'h0000_1234, 32'h0, 32'hffff_ffff);
    add_test("div_ovf", ALU_DIV, VEC_MODE32, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    add_test("rem_ovf", ALU_REM, VEC_MODE32, 32'h8000_0000, 32'hffff_ffff, 32'h0);
    // every kept operator is a candidate for the random part
    op = op.first();
    repeat (op.num()) begin
      ops.push_back(op);
      op = op.next();
    end
    repeat (40) begin
      r = {$random(seed)} % 3;
      m = (r == 0) ? VEC_MODE32 : ((r == 1) ? VEC_MODE16 : VEC_MODE8);
      r = {$random(seed)} % ops.size();
      tests.push_back('{name: "random", op: ops[r], mode: m, a: $random(seed),
                        b: $random(seed), exp: '0, use_model: 1'b1});
    end
  endtask

  // watchdog sized from the test count
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout, the run did not finish within %0d ns", limit_ns);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int low_left;
    clk           = 1'b0;
    rst_i         = 1'b1;
    enable_i      = 1'b0;
    operator_i    = ALU_AND;
    vector_mode_i = VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    ex_ready_i    = 1'b0;
    exp_val       = '0;
    use_model     = 1'b0;
    test_name     = '0;
    seed          = 47746;
    build_table();
    limit_ns      = tests.size() * (33 + 4) * 4 + 3 * 4;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    foreach (tests[i]) begin
      // pipeline stalls 0 to 3 cycles once the ALU is ready
      low_left      = {$random(seed)} % 4;
      enable_i      <= 1'b1;
      operator_i    <= tests[i].op;
      vector_mode_i <= tests[i].mode;
      operand_a_i   <= tests[i].a;
      operand_b_i   <= tests[i].b;
      exp_val       <= tests[i].exp;
      use_model     <= tests[i].use_model;
      test_name     <= tests[i].name;
      ex_ready_i    <= (low_left == 0);
      @(posedge clk);
      while (!(enable_i && ready_o && ex_ready_i)) begin
        if (ready_o) begin
          low_left--;
          if (low_left == 0) ex_ready_i <= 1'b1;
        end
        @(posedge clk);
      end
    end
    enable_i   <= 1'b0;
    ex_ready_i <= 1'b1;
    @(posedge clk);
    $display("tests %0d, checked %0d, failed %0d", tests.size(), n_checked, n_errors);
    if (n_errors == 0 && n_checked == tests.size()) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
alu_pkg.sv
alu_vec_adder.sv
alu_vec_shifter.sv
alu_vec_compare.sv
alu_serial_div.sv
alu_top.sv
tb_alu_sva.sv
tb_alu_checker.sv
tb_alu.sv

/* Makefile */
# Verilator flow for the ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_alu
RTL_TOP   ?= alu_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) alu_settings.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)
